// ==== Bender.yml ====
package:
  name: calculator

sources:
  - source/calc_pkg.sv
  - source/key_latch.sv
  - source/addsub_unit.sv
  - source/shift_add_multiplier.sv
  - source/calc_controller.sv
  - source/calculator_top.sv
  - target: test
    files:
      - test/calculator_asserts.sv
      - test/calculator_checker.sv
      - test/calculator_tb.sv

// ==== source/addsub_unit.sv ====
// Registered adder and subtractor
`timescale 1ns/1ps
`default_nettype none

module addsub_unit (
    input  logic                        clk,
    input  logic                        nRST,
    input  logic                        start,
    input  logic                        sub,
    input  logic [calc_pkg::DATA_W-1:0] a,
    input  logic [calc_pkg::DATA_W-1:0] b,
    output logic [calc_pkg::DATA_W-1:0] result,
    output logic                        finish
);

    // One cycle of latency
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            finish <= 1'b0;
        end else begin
            finish <= start;
        end
    end

    // Wraps modulo 2^16, held until the next start
    always_ff @(posedge clk) begin
        if (start) begin
            if (sub) begin
                result <= a - b;
            end else begin
                result <= a + b;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/calc_controller.sv ====
// Calculator operand and operation FSM
`timescale 1ns/1ps
`default_nettype none

module calc_controller (
    input  logic                        clk,
    input  logic                        nRST,
    input  logic                        read_input,
    input  logic [calc_pkg::KEY_W-1:0]  held_digit,
    input  calc_pkg::op_code_t          operator_input,
    input  logic                        equal_input,
    input  logic [calc_pkg::DATA_W-1:0] alu_result,
    input  logic                        alu_finish,
    input  logic [calc_pkg::DATA_W-1:0] mult_product,
    input  logic                        mult_finish,
    output logic                        key_read,
    output logic [calc_pkg::DATA_W-1:0] alu_a,
    output logic [calc_pkg::DATA_W-1:0] alu_b,
    output logic                        alu_sub,
    output logic                        alu_start,
    output logic [calc_pkg::DATA_W-1:0] mult_a,
    output logic [calc_pkg::DATA_W-1:0] mult_b,
    output logic                        mult_start,
    output logic [calc_pkg::DATA_W-1:0] display,
    output logic                        complete
);

    calc_pkg::calc_state_t       state;
    calc_pkg::calc_state_t       next_state;
    calc_pkg::op_code_t          pending_op;
    logic [calc_pkg::DATA_W-1:0] operand1;
    logic [calc_pkg::DATA_W-1:0] operand2;
    logic [calc_pkg::KEY_W-1:0]  latched_digit;
    logic [calc_pkg::DATA_W-1:0] digit_ext;
    logic                        in_wait;
    logic                        key_new;
    logic                        take_digit;
    logic                        take_neg;
    logic                        take_arith;
    logic                        take_equal;

    assign in_wait = (state == calc_pkg::WAIT_OP1) || (state == calc_pkg::WAIT_OP2);
    // Held key is stale while its acknowledge is out
    assign key_new    = in_wait && !key_read;
    assign take_digit = key_new && read_input;
    assign take_neg   = key_new && (operator_input == calc_pkg::OP_NEG);
    assign take_arith = key_new && (operator_input != calc_pkg::OP_NONE)
                        && (operator_input != calc_pkg::OP_NEG);
    assign take_equal = key_new && equal_input;
    assign digit_ext  = {{(calc_pkg::DATA_W - calc_pkg::KEY_W){1'b0}}, latched_digit};

    always_comb begin
        next_state = state;
        case (state)
            calc_pkg::WAIT_OP1: begin
                if (take_digit) begin
                    next_state = calc_pkg::WAIT_MULT_OP1;
                end else if (take_arith) begin
                    next_state = calc_pkg::WAIT_OP2;
                end
            end
            calc_pkg::WAIT_MULT_OP1: begin
                if (mult_finish) begin
                    next_state = calc_pkg::ADD_KEY_OP1;
                end
            end
            calc_pkg::ADD_KEY_OP1:  next_state = calc_pkg::WAIT_OP1;
            calc_pkg::WAIT_OP2: begin
                if (take_digit) begin
                    next_state = calc_pkg::WAIT_MULT_OP2;
                end else if (take_equal) begin
                    next_state = calc_pkg::SEND_TO_COMPUTE;
                end
            end
            calc_pkg::WAIT_MULT_OP2: begin
                if (mult_finish) begin
                    next_state = calc_pkg::ADD_KEY_OP2;
                end
            end
            calc_pkg::ADD_KEY_OP2:     next_state = calc_pkg::WAIT_OP2;
            calc_pkg::SEND_TO_COMPUTE: next_state = calc_pkg::WAIT_COMPUTE;
            calc_pkg::WAIT_COMPUTE: begin
                if (alu_finish) begin
                    next_state = calc_pkg::SHOW_RESULT_ADDSUB;
                end else if (mult_finish) begin
                    next_state = calc_pkg::SHOW_RESULT_MULT;
                end
            end
            default: next_state = calc_pkg::WAIT_OP1;
        endcase
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state      <= calc_pkg::WAIT_OP1;
            pending_op <= calc_pkg::OP_NONE;
            operand1   <= '0;
            operand2   <= '0;
            key_read   <= 1'b0;
            alu_sub    <= 1'b0;
            alu_start  <= 1'b0;
            mult_start <= 1'b0;
            display    <= '0;
            complete   <= 1'b0;
        end else begin
            state      <= next_state;
            key_read   <= take_digit || take_neg || take_arith || take_equal;
            alu_start  <= 1'b0;
            mult_start <= 1'b0;
            complete   <= 1'b0;
            case (state)
                calc_pkg::WAIT_OP1: begin
                    display    <= operand1;
                    mult_start <= take_digit;
                    if (take_neg) begin
                        operand1[calc_pkg::DATA_W-1] <= 1'b1;
                    end
                    if (take_arith) begin
                        pending_op <= operator_input;
                    end
                end
                calc_pkg::WAIT_MULT_OP1: begin
                    if (mult_finish) begin
                        operand1 <= mult_product;
                    end
                end
                calc_pkg::ADD_KEY_OP1: operand1 <= operand1 + digit_ext;
                calc_pkg::WAIT_OP2: begin
                    display    <= operand2;
                    mult_start <= take_digit;
                    if (take_neg) begin
                        operand2[calc_pkg::DATA_W-1] <= 1'b1;
                    end
                end
                calc_pkg::WAIT_MULT_OP2: begin
                    if (mult_finish) begin
                        operand2 <= mult_product;
                    end
                end
                calc_pkg::ADD_KEY_OP2: operand2 <= operand2 + digit_ext;
                calc_pkg::SEND_TO_COMPUTE: begin
                    if (pending_op == calc_pkg::OP_MUL) begin
                        mult_start <= 1'b1;
                    end else begin
                        alu_start <= 1'b1;
                        alu_sub   <= (pending_op == calc_pkg::OP_SUB);
                    end
                end
                calc_pkg::SHOW_RESULT_ADDSUB: begin
                    operand1 <= alu_result;
                    operand2 <= '0;
                    display  <= alu_result;
                    complete <= 1'b1;
                end
                calc_pkg::SHOW_RESULT_MULT: begin
                    operand1 <= mult_product;
                    operand2 <= '0;
                    display  <= mult_product;
                    complete <= 1'b1;
                end
                default: operand2 <= operand2;
            endcase
        end
    end

    // Operands for the arithmetic units
    always_ff @(posedge clk) begin
        if (take_digit) begin
            latched_digit <= held_digit;
            mult_a        <= (state == calc_pkg::WAIT_OP2) ? operand2 : operand1;
            mult_b        <= calc_pkg::RADIX;
        end else if (state == calc_pkg::SEND_TO_COMPUTE) begin
            mult_a <= operand1;
            mult_b <= operand2;
            alu_a  <= operand1;
            alu_b  <= operand2;
        end
    end

endmodule

`default_nettype wire

// ==== source/calc_pkg.sv ====
// Calculator shared definitions
`default_nettype none

package calc_pkg;

    localparam int DATA_W = 16;
    localparam int KEY_W  = 4;
    localparam int OP_W   = 3;

    // Decimal shift applied before each new digit
    localparam logic [DATA_W-1:0] RADIX = 16'd10;

    // Multiplier step counter
    localparam int STEP_W = $clog2(DATA_W);
    localparam logic [STEP_W-1:0] LAST_STEP = STEP_W'(DATA_W - 1);

    typedef enum logic [OP_W-1:0] {
        OP_NONE = 3'd0,
        OP_NEG  = 3'd1,
        OP_ADD  = 3'd2,
        OP_SUB  = 3'd3,
        OP_MUL  = 3'd4
    } op_code_t;

    typedef enum logic [3:0] {
        WAIT_OP1,
        WAIT_MULT_OP1,
        ADD_KEY_OP1,
        WAIT_OP2,
        WAIT_MULT_OP2,
        ADD_KEY_OP2,
        SEND_TO_COMPUTE,
        WAIT_COMPUTE,
        SHOW_RESULT_ADDSUB,
        SHOW_RESULT_MULT
    } calc_state_t;

endpackage

`default_nettype wire

// ==== source/calculator_top.sv ====
// Keypad calculator core
`timescale 1ns/1ps
`default_nettype none

module calculator_top (
    input  logic                        clk,
    input  logic                        nRST,
    input  logic                        digit_strobe,
    input  logic [calc_pkg::KEY_W-1:0]  digit,
    input  logic                        op_strobe,
    input  calc_pkg::op_code_t          op,
    input  logic                        equal_strobe,
    output logic                        key_pending,
    output logic [calc_pkg::DATA_W-1:0] display,
    output logic                        complete
);

    logic                        read_input;
    calc_pkg::op_code_t          operator_input;
    logic                        equal_input;
    logic [calc_pkg::KEY_W-1:0]  held_digit;
    logic                        key_read;
    logic [calc_pkg::DATA_W-1:0] alu_a;
    logic [calc_pkg::DATA_W-1:0] alu_b;
    logic [calc_pkg::DATA_W-1:0] alu_sum;
    logic                        alu_sub;
    logic                        alu_start;
    logic                        alu_finish;
    logic [calc_pkg::DATA_W-1:0] mult_a;
    logic [calc_pkg::DATA_W-1:0] mult_b;
    logic [calc_pkg::DATA_W-1:0] mult_product;
    logic                        mult_start;
    logic                        mult_finish;

    key_latch u_key_latch (
        .clk            (clk),
        .nRST           (nRST),
        .digit_strobe   (digit_strobe),
        .digit          (digit),
        .op_strobe      (op_strobe),
        .op             (op),
        .equal_strobe   (equal_strobe),
        .key_read       (key_read),
        .read_input     (read_input),
        .operator_input (operator_input),
        .equal_input    (equal_input),
        .held_digit     (held_digit),
        .key_pending    (key_pending)
    );

    calc_controller u_controller (
        .clk            (clk),
        .nRST           (nRST),
        .read_input     (read_input),
        .held_digit     (held_digit),
        .operator_input (operator_input),
        .equal_input    (equal_input),
        .alu_result     (alu_sum),
        .alu_finish     (alu_finish),
        .mult_product   (mult_product),
        .mult_finish    (mult_finish),
        .key_read       (key_read),
        .alu_a          (alu_a),
        .alu_b          (alu_b),
        .alu_sub        (alu_sub),
        .alu_start      (alu_start),
        .mult_a         (mult_a),
        .mult_b         (mult_b),
        .mult_start     (mult_start),
        .display        (display),
        .complete       (complete)
    );

    addsub_unit u_addsub (
        .clk    (clk),
        .nRST   (nRST),
        .start  (alu_start),
        .sub    (alu_sub),
        .a      (alu_a),
        .b      (alu_b),
        .result (alu_sum),
        .finish (alu_finish)
    );

    shift_add_multiplier u_mult (
        .clk     (clk),
        .nRST    (nRST),
        .start   (mult_start),
        .a       (mult_a),
        .b       (mult_b),
        .product (mult_product),
        .finish  (mult_finish)
    );

endmodule

`default_nettype wire

// ==== source/key_latch.sv ====
// Key event latch
`timescale 1ns/1ps
`default_nettype none

module key_latch (
    input  logic                         clk,
    input  logic                         nRST,
    input  logic                         digit_strobe,
    input  logic [calc_pkg::KEY_W-1:0]   digit,
    input  logic                         op_strobe,
    input  calc_pkg::op_code_t           op,
    input  logic                         equal_strobe,
    input  logic                         key_read,
    output logic                         read_input,
    output calc_pkg::op_code_t           operator_input,
    output logic                         equal_input,
    output logic [calc_pkg::KEY_W-1:0]   held_digit,
    output logic                         key_pending
);

    logic accept_digit;
    logic accept_op;
    logic accept_equal;

    // Digits win over operators, operators over equal
    assign accept_digit = !key_pending && digit_strobe;
    assign accept_op    = !key_pending && !digit_strobe && op_strobe
                          && (op != calc_pkg::OP_NONE);
    assign accept_equal = !key_pending && !digit_strobe && !op_strobe && equal_strobe;

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            read_input     <= 1'b0;
            operator_input <= calc_pkg::OP_NONE;
            equal_input    <= 1'b0;
            key_pending    <= 1'b0;
        end else if (key_read) begin
            read_input     <= 1'b0;
            operator_input <= calc_pkg::OP_NONE;
            equal_input    <= 1'b0;
            key_pending    <= 1'b0;
        end else if (!key_pending) begin
            read_input     <= accept_digit;
            operator_input <= accept_op ? op : calc_pkg::OP_NONE;
            equal_input    <= accept_equal;
            key_pending    <= accept_digit || accept_op || accept_equal;
        end
    end

    always_ff @(posedge clk) begin
        if (accept_digit) begin
            held_digit <= digit;
        end
    end

endmodule

`default_nettype wire

// ==== source/shift_add_multiplier.sv ====
// Sequential shift and add multiplier
`timescale 1ns/1ps
`default_nettype none

module shift_add_multiplier (
    input  logic                        clk,
    input  logic                        nRST,
    input  logic                        start,
    input  logic [calc_pkg::DATA_W-1:0] a,
    input  logic [calc_pkg::DATA_W-1:0] b,
    output logic [calc_pkg::DATA_W-1:0] product,
    output logic                        finish
);

    logic                        busy;
    logic [calc_pkg::STEP_W-1:0] step;
    logic [calc_pkg::DATA_W-1:0] mcand;
    logic [calc_pkg::DATA_W-1:0] mplier;
    logic [calc_pkg::DATA_W-1:0] acc;

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            busy   <= 1'b0;
            step   <= '0;
            finish <= 1'b0;
        end else begin
            finish <= 1'b0;
            if (start && !busy) begin
                busy <= 1'b1;
                step <= '0;
            end else if (busy) begin
                step <= step + 1'b1;
                if (step == calc_pkg::LAST_STEP) begin
                    busy   <= 1'b0;
                    finish <= 1'b1;
                end
            end
        end
    end

    // One multiplier bit per cycle, upper product bits fall off
    always_ff @(posedge clk) begin
        if (start && !busy) begin
            mcand  <= a;
            mplier <= b;
            acc    <= '0;
        end else if (busy) begin
            if (mplier[0]) begin
                acc <= acc + mcand;
            end
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    assign product = acc;

endmodule

`default_nettype wire

// ==== test/calculator_asserts.sv ====
// Controller protocol assertions
`timescale 1ns/1ps
`default_nettype none

module calculator_asserts (
    input logic                  clk,
    input logic                  nRST,
    input logic                  key_read,
    input logic                  alu_start,
    input logic                  mult_start,
    input logic                  complete,
    input calc_pkg::calc_state_t state
);

    single_ack: assert property (@(posedge clk) disable iff (!nRST)
        key_read |=> !key_read)
        else $error("key_read high in two cycles in a row");

    one_unit_started: assert property (@(posedge clk) disable iff (!nRST)
        !(alu_start && mult_start))
        else $error("alu_start and mult_start high together");

    // Result states last one cycle and raise complete on exit
    complete_after_result: assert property (@(posedge clk) disable iff (!nRST)
        complete |-> $past(state == calc_pkg::SHOW_RESULT_ADDSUB
                           || state == calc_pkg::SHOW_RESULT_MULT))
        else $error("complete without a preceding result state");

endmodule

`default_nettype wire

// ==== test/calculator_checker.sv ====
// Calculator output checker
`timescale 1ns/1ps
`default_nettype none

module calculator_checker (
    input  logic                        clk,
    input  logic                        nRST,
    input  logic [calc_pkg::DATA_W-1:0] display,
    input  logic                        complete,
    input  logic                        key_pending,
    input  logic                        entry_check,
    input  logic [calc_pkg::DATA_W-1:0] entry_expect,
    input  logic                        expect_result,
    input  logic [calc_pkg::DATA_W-1:0] result_expect,
    output int                          check_count,
    output int                          error_count
);

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("CHECK FAILED %s expected 0x%0h got 0x%0h at %0t",
                     name, expected, actual, $time);
        end
    endtask

    initial begin
        check_count = 0;
        error_count = 0;
    end

    always @(negedge clk) begin
        if (nRST) begin
            if (complete) begin
                if (expect_result) begin
                    compare_value("display", result_expect, display);
                end else begin
                    error_count++;
                    $display("ERROR: complete pulsed with no calculation pending at %0t",
                             $time);
                end
            end
            if (entry_check) begin
                compare_value("display", entry_expect, display);
                compare_value("key_pending", 32'd0, key_pending);
                compare_value("complete", 32'd0, complete);
            end
        end
    end

endmodule

`default_nettype wire

// ==== test/calculator_tb.sv ====
// Calculator testbench
`timescale 1ns/1ps
`default_nettype none

module calculator_tb;

    localparam int WAIT_LIMIT = 100;

    logic                        clk;
    logic                        nRST;
    logic                        digit_strobe;
    logic [calc_pkg::KEY_W-1:0]  digit;
    logic                        op_strobe;
    calc_pkg::op_code_t          op;
    logic                        equal_strobe;
    logic                        key_pending;
    logic [calc_pkg::DATA_W-1:0] display;
    logic                        complete;
    logic                        entry_check;
    logic [calc_pkg::DATA_W-1:0] entry_expect;
    logic                        expect_result;
    logic [calc_pkg::DATA_W-1:0] result_expect;
    int                          check_count;
    int                          error_count;
    int                          timeout_count;

    // Reference model state
    logic [calc_pkg::DATA_W-1:0] op1;
    logic [calc_pkg::DATA_W-1:0] op2;
    logic                        second;
    calc_pkg::op_code_t          op_sel;

    calculator_top u_dut (
        .clk          (clk),
        .nRST         (nRST),
        .digit_strobe (digit_strobe),
        .digit        (digit),
        .op_strobe    (op_strobe),
        .op           (op),
        .equal_strobe (equal_strobe),
        .key_pending  (key_pending),
        .display      (display),
        .complete     (complete)
    );

    calculator_checker u_checker (
        .clk           (clk),
        .nRST          (nRST),
        .display       (display),
        .complete      (complete),
        .key_pending   (key_pending),
        .entry_check   (entry_check),
        .entry_expect  (entry_expect),
        .expect_result (expect_result),
        .result_expect (result_expect),
        .check_count   (check_count),
        .error_count   (error_count)
    );

    bind calc_controller calculator_asserts u_asserts (
        .clk        (clk),
        .nRST       (nRST),
        .key_read   (key_read),
        .alu_start  (alu_start),
        .mult_start (mult_start),
        .complete   (complete),
        .state      (state)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // OP_NONE stands for digit entry, rhs then holds the digit
    function automatic logic [calc_pkg::DATA_W-1:0] calc_expect(
        input calc_pkg::op_code_t          kind,
        input logic [calc_pkg::DATA_W-1:0] lhs,
        input logic [calc_pkg::DATA_W-1:0] rhs
    );
        logic [2*calc_pkg::DATA_W-1:0] wide;
        case (kind)
            calc_pkg::OP_NEG: wide = lhs | 16'h8000;
            calc_pkg::OP_ADD: wide = lhs + rhs;
            calc_pkg::OP_SUB: wide = lhs - rhs;
            calc_pkg::OP_MUL: wide = lhs * rhs;
            default:          wide = lhs * calc_pkg::RADIX + rhs;
        endcase
        return wide[calc_pkg::DATA_W-1:0];
    endfunction

    function automatic logic controller_idle();
        return (u_dut.u_controller.state == calc_pkg::WAIT_OP1)
            || (u_dut.u_controller.state == calc_pkg::WAIT_OP2);
    endfunction

    task automatic apply_reset();
        @(posedge clk);
        nRST <= 1'b0;
        op1    = '0;
        op2    = '0;
        second = 1'b0;
        op_sel = calc_pkg::OP_NONE;
        repeat (10) @(posedge clk);
        nRST <= 1'b1;
    endtask

    task automatic wait_key_free();
        int cycles;
        cycles = 0;
        while (key_pending && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (key_pending) begin
            $display("ERROR: key_pending stayed high, the next key cannot be sent");
            timeout_count++;
        end
    endtask

    task automatic wait_idle();
        int cycles;
        cycles = 0;
        @(posedge clk);
        while ((key_pending || !controller_idle()) && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (key_pending || !controller_idle()) begin
            $display("ERROR: controller did not return to a wait state after a key");
            timeout_count++;
        end
    endtask

    task automatic wait_complete();
        int cycles;
        cycles = 0;
        @(posedge clk);
        while (!complete && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (!complete) begin
            $display("ERROR: no complete pulse arrived after the equal key");
            timeout_count++;
        end
    endtask

    task automatic strobe_key(input logic is_digit, input logic is_op, input logic is_equal,
                              input logic [calc_pkg::KEY_W-1:0] d,
                              input calc_pkg::op_code_t o);
        wait_key_free();
        @(posedge clk);
        digit_strobe <= is_digit;
        digit        <= d;
        op_strobe    <= is_op;
        op           <= o;
        equal_strobe <= is_equal;
        @(posedge clk);
        digit_strobe <= 1'b0;
        op_strobe    <= 1'b0;
        equal_strobe <= 1'b0;
    endtask

    task automatic check_entry(input logic [calc_pkg::DATA_W-1:0] value);
        repeat (2) @(posedge clk);
        entry_expect <= value;
        entry_check  <= 1'b1;
        @(posedge clk);
        entry_check  <= 1'b0;
    endtask

    task automatic enter_digit(input logic [calc_pkg::KEY_W-1:0] d);
        strobe_key(1'b1, 1'b0, 1'b0, d, calc_pkg::OP_NONE);
        wait_idle();
        if (second) begin
            op2 = calc_expect(calc_pkg::OP_NONE, op2, {12'd0, d});
        end else begin
            op1 = calc_expect(calc_pkg::OP_NONE, op1, {12'd0, d});
        end
        check_entry(second ? op2 : op1);
    endtask

    task automatic enter_number(input int count);
        repeat (count) enter_digit(4'($urandom_range(9)));
    endtask

    task automatic enter_op(input calc_pkg::op_code_t o);
        strobe_key(1'b0, 1'b1, 1'b0, '0, o);
        wait_idle();
        if (o == calc_pkg::OP_NEG) begin
            if (second) begin
                op2 = calc_expect(o, op2, '0);
            end else begin
                op1 = calc_expect(o, op1, '0);
            end
        end else if (!second) begin
            second = 1'b1;
            op_sel = o;
        end
        check_entry(second ? op2 : op1);
    endtask

    // Equal outside operand 2 entry is acknowledged and ignored
    task automatic enter_equal();
        if (second) begin
            result_expect <= calc_expect(op_sel, op1, op2);
            expect_result <= 1'b1;
            strobe_key(1'b0, 1'b0, 1'b1, '0, calc_pkg::OP_NONE);
            wait_complete();
            expect_result <= 1'b0;
            op1    = calc_expect(op_sel, op1, op2);
            op2    = '0;
            second = 1'b0;
        end else begin
            strobe_key(1'b0, 1'b0, 1'b1, '0, calc_pkg::OP_NONE);
        end
        wait_idle();
        check_entry(op1);
    endtask

    initial begin
        void'($urandom(4410));
        nRST          = 1'b0;
        digit_strobe  = 1'b0;
        digit         = '0;
        op_strobe     = 1'b0;
        op            = calc_pkg::OP_NONE;
        equal_strobe  = 1'b0;
        entry_check   = 1'b0;
        entry_expect  = '0;
        expect_result = 1'b0;
        result_expect = '0;
        timeout_count = 0;

        // Reset state and plain entry
        apply_reset();
        check_entry('0);
        enter_number(5);

        repeat (6) begin
            apply_reset();
            enter_number(1 + $urandom_range(3));
            enter_op($urandom_range(1) ? calc_pkg::OP_ADD : calc_pkg::OP_SUB);
            enter_number(1 + $urandom_range(3));
            enter_equal();
        end

        // Products wider than 16 bits included
        repeat (6) begin
            apply_reset();
            enter_number(2 + $urandom_range(3));
            enter_op(calc_pkg::OP_MUL);
            enter_number(1 + $urandom_range(3));
            enter_equal();
        end

        repeat (3) begin
            apply_reset();
            enter_number(1 + $urandom_range(2));
            enter_op(calc_pkg::OP_NEG);
            enter_op($urandom_range(1) ? calc_pkg::OP_ADD : calc_pkg::OP_MUL);
            enter_number(1 + $urandom_range(2));
            enter_op(calc_pkg::OP_NEG);
            enter_equal();
        end

        // Chained results and ignored keys
        apply_reset();
        enter_equal();
        enter_number(3);
        enter_equal();
        enter_op(calc_pkg::OP_ADD);
        enter_number(2);
        enter_op(calc_pkg::OP_SUB);
        enter_equal();
        enter_op(calc_pkg::OP_MUL);
        enter_number(2);
        enter_equal();
        enter_op(calc_pkg::OP_SUB);
        enter_number(3);
        enter_equal();
        enter_equal();

        repeat (2) @(posedge clk);
        $display("Checks: %0d  errors: %0d  timeouts: %0d",
                 check_count, error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
source/calc_pkg.sv
source/key_latch.sv
source/addsub_unit.sv
source/shift_add_multiplier.sv
source/calc_controller.sv
source/calculator_top.sv
test/calculator_asserts.sv
test/calculator_checker.sv
test/calculator_tb.sv
